/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_vg_subsys
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/vg_clock_gen.sv */
`timescale 1ns/1ps

module vg_clock_gen
(
	input  logic fclk,
	input  logic rst_n,
	input  logic step,   // head step from the vg93
	input  logic vg_drq, // data request, ends turbo
	output logic vg_clk
);

	typedef enum logic {
		clk_normal = 1'b0, // 1 MHz controller clock
		clk_turbo  = 1'b1  // 2 MHz while seeking
	} turbo_state_e;

	turbo_state_e turbo_state;
	logic [2:0]   step_sync;
	logic [2:0]   drq_sync;
	logic         step_rise; // registered rising edge of step
	logic         drq_rise;  // registered rising edge of vg_drq
	logic [2:0]   div7_cnt;
	logic         strobe7;   // 4 MHz tick
	logic [1:0]   johnson;

	// input sync and edge detect
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			step_sync <= '0;
			drq_sync  <= '0;
			step_rise <= 1'b0;
			drq_rise  <= 1'b0;
		end
		else
		begin
			step_sync <= {step_sync[1:0], step};
			drq_sync  <= {drq_sync[1:0], vg_drq};
			step_rise <= step_sync[1] & ~step_sync[2];
			drq_rise  <= drq_sync[1] & ~drq_sync[2];
		end
	end

	// turbo fsm, drq has priority over a step in the same cycle
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			turbo_state <= clk_normal;
		else if (drq_rise)
			turbo_state <= clk_normal;
		else if (step_rise)
			turbo_state <= clk_turbo;
	end

	assign strobe7 = (div7_cnt == 3'd6); // 28/7

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			div7_cnt <= 3'd0;
		else if (strobe7)
			div7_cnt <= 3'd0;
		else
			div7_cnt <= div7_cnt + 3'd1;
	end

	// two-bit johnson ring divides by 4, in turbo the top bit just toggles
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			johnson <= 2'b00;
		else if (strobe7)
		begin
			johnson[0] <= ~johnson[1];
			if (turbo_state == clk_turbo)
				johnson[1] <= ~johnson[1]; // period 2 strobes
			else
				johnson[1] <= johnson[0];  // period 4 strobes
		end
	end

	assign vg_clk = johnson[1];

endmodule

/* design/vg_pkg.sv */
package vg_pkg;

	// port #FF outputs, one bit per din line except the drive select pair
	typedef struct packed {
		logic       side;      // disk side, inverted din[4]
		logic       hrdy;      // head load for the vg93 hrdy pin, din[3]
		logic       res_n;     // vg93 reset, low until software sets din[2]
		logic [1:0] drive_sel; // to the drive select decoder, din[1:0]
	} vg_sys_t;

	// precompensation condition lines straight from the controller
	typedef struct packed {
		logic sl;   // early bit, shift left
		logic tr43; // head beyond track 43
		logic sr;   // late bit, shift right
	} fdd_precomp_t;

	// shift class decoded from sl/tr43/sr
	typedef enum logic [2:0] {
		shift_none        = 3'd0,
		shift_outer_left  = 3'd1,
		shift_outer_right = 3'd2,
		shift_inner_left  = 3'd3,
		shift_inner_right = 3'd4
	} precomp_shift_e;

	// write pulse delays in fclk cycles
	localparam logic [3:0] wrdelay_outer_left  = 4'd4;
	localparam logic [3:0] wrdelay_outer_right = 4'd11;
	localparam logic [3:0] wrdelay_inner_left  = 4'd0;  // strongest shift left
	localparam logic [3:0] wrdelay_inner_right = 4'd14; // strongest shift right
	localparam logic [3:0] wrdelay_standard    = 4'd7;  // centre, no shift

	// fclk cycles per vg_rclk half period, 112 cycles full period at 28 MHz
	localparam logic [5:0] rclk_half_default = 6'd56;

endpackage

/* design/vg_read_restore.sv */
`timescale 1ns/1ps

module vg_read_restore
#(
	parameter logic [5:0] rclk_half = vg_pkg::rclk_half_default
)
(
	input  logic fclk,
	input  logic rst_n,
	input  logic rdat_n,  // raw read data from the drive, active low
	output logic vg_rawr, // 4 cycle active low pulse to the vg93
	output logic vg_rclk  // regenerated read clock
);

	logic [4:0] rdat_sync;   // glitch filter, active high
	logic       rdat_edge1;  // acceptance latch
	logic       rdat_edge2;
	logic       rdat;        // one cycle per accepted pulse
	logic [2:0] rwidth_cnt;  // 0..4, bit 2 marks idle
	logic       rwidth_ena;
	logic [5:0] rclk_cnt;
	logic       rclk_strobe;
	logic       rclk_tick;   // strobe delayed one cycle for the toggle

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			rdat_sync <= 5'b00000;
		else
			rdat_sync <= {rdat_sync[3:0], ~rdat_n};
	end

	// four low samples in a row open the latch, the rclk strobe closes it
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rdat_edge1 <= 1'b0;
			rdat_edge2 <= 1'b0;
		end
		else
		begin
			if (rdat_sync[4:1] == 4'b1111)
				rdat_edge1 <= 1'b1;
			else if (rclk_strobe)
				rdat_edge1 <= 1'b0; // one pulse per half period at most
			rdat_edge2 <= rdat_edge1;
		end
	end

	assign rdat = rdat_edge1 & ~rdat_edge2;

	// rawr width
	assign rwidth_ena = rdat | ~rwidth_cnt[2];

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			rwidth_cnt <= 3'd4; // idle
		else if (rwidth_ena)
		begin
			if (rdat)
				rwidth_cnt <= 3'd0; // restart on every accepted pulse
			else
				rwidth_cnt <= rwidth_cnt + 3'd1;
		end
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			vg_rawr <= 1'b1;
		else
			vg_rawr <= rwidth_cnt[2];
	end

	assign rclk_strobe = (rclk_cnt == 6'd0);

	// a pulse recentres the clock edge, otherwise it free-runs
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			rclk_cnt <= rclk_half - 6'd1;
		else if (rdat)
			rclk_cnt <= (rclk_half >> 1) + 6'd1; // half period plus the rawr centre
		else if (rclk_strobe)
			rclk_cnt <= rclk_half - 6'd1;
		else
			rclk_cnt <= rclk_cnt - 6'd1;
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rclk_tick <= 1'b0;
			vg_rclk   <= 1'b0;
		end
		else
		begin
			rclk_tick <= rclk_strobe;
			if (rclk_tick)
				vg_rclk <= ~vg_rclk;
		end
	end

endmodule

/* design/vg_subsys.sv */
`timescale 1ns/1ps

module vg_subsys
#(
	parameter logic [3:0] delay_outer_left  = vg_pkg::wrdelay_outer_left,
	parameter logic [3:0] delay_outer_right = vg_pkg::wrdelay_outer_right,
	parameter logic [3:0] delay_inner_left  = vg_pkg::wrdelay_inner_left,
	parameter logic [3:0] delay_inner_right = vg_pkg::wrdelay_inner_right,
	parameter logic [3:0] delay_standard    = vg_pkg::wrdelay_standard,
	parameter logic [5:0] rclk_half         = vg_pkg::rclk_half_default
)
(
	input  logic                 fclk,    // 28 MHz
	input  logic                 rst_n,
	// cpu side of port #FF
	input  logic [7:0]           din,
	input  logic                 wr_ff,
	output vg_pkg::vg_sys_t      sys,
	output logic                 intrq,
	output logic                 drq,
	// vg93 side
	input  logic                 vg_irq,
	input  logic                 vg_drq,  // also ends turbo
	input  logic                 step,
	output logic                 vg_clk,
	input  vg_pkg::fdd_precomp_t precomp,
	input  logic                 vg_wd,
	output logic                 vg_wrd,
	// drive read path
	input  logic                 rdat_n,
	output logic                 vg_rawr,
	output logic                 vg_rclk
);

	vg_clock_gen vg_clock_gen_inst
	(
		.fclk   (fclk),
		.rst_n  (rst_n),
		.step   (step),
		.vg_drq (vg_drq),
		.vg_clk (vg_clk)
	);

	vg_sysreg vg_sysreg_inst
	(
		.fclk   (fclk),
		.rst_n  (rst_n),
		.wr_ff  (wr_ff),
		.din    (din),
		.sys    (sys),
		.vg_irq (vg_irq),
		.vg_drq (vg_drq),
		.intrq  (intrq),
		.drq    (drq)
	);

	// precomp delays passed straight through from the top
	vg_write_precomp #(
		.delay_outer_left  (delay_outer_left),
		.delay_outer_right (delay_outer_right),
		.delay_inner_left  (delay_inner_left),
		.delay_inner_right (delay_inner_right),
		.delay_standard    (delay_standard)
	) vg_write_precomp_inst
	(
		.fclk    (fclk),
		.rst_n   (rst_n),
		.precomp (precomp),
		.vg_wd   (vg_wd),
		.vg_wrd  (vg_wrd)
	);

	vg_read_restore #(
		.rclk_half (rclk_half)
	) vg_read_restore_inst
	(
		.fclk    (fclk),
		.rst_n   (rst_n),
		.rdat_n  (rdat_n),
		.vg_rawr (vg_rawr),
		.vg_rclk (vg_rclk)
	);

endmodule

/* design/vg_sysreg.sv */
`timescale 1ns/1ps

module vg_sysreg
(
	input  logic            fclk,
	input  logic            rst_n,
	input  logic            wr_ff,  // one fclk strobe per port #FF write
	input  logic [7:0]      din,
	output vg_pkg::vg_sys_t sys,
	input  logic            vg_irq,
	input  logic            vg_drq,
	output logic            intrq,  // resynced for the port #FF read
	output logic            drq
);

	logic       wr_ff_q;   // delayed write strobe
	logic [4:0] din_q;     // din[4:0] captured with the strobe
	logic [1:0] irq_sync;
	logic [1:0] drq_sync;

	// the cpu write is captured here and the fields load one cycle later
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ff_q <= 1'b0;
			din_q   <= 5'h00;
		end
		else
		begin
			wr_ff_q <= wr_ff;
			if (wr_ff)
				din_q <= din[4:0];
		end
	end

	// res_n stays low from reset until software writes a 1
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			sys <= '0;
		else if (wr_ff_q)
		begin
			sys.side      <= ~din_q[4]; // side line is active low at the drive
			sys.hrdy      <= din_q[3];
			sys.res_n     <= din_q[2];
			sys.drive_sel <= din_q[1:0];
		end
	end

	// two-flop resync and a registered output
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			irq_sync <= 2'b00;
			drq_sync <= 2'b00;
			intrq    <= 1'b0;
			drq      <= 1'b0;
		end
		else
		begin
			irq_sync <= {irq_sync[0], vg_irq};
			drq_sync <= {drq_sync[0], vg_drq};
			intrq    <= irq_sync[1];
			drq      <= drq_sync[1];
		end
	end

endmodule

/* design/vg_write_precomp.sv */
`timescale 1ns/1ps

module vg_write_precomp
#(
	parameter logic [3:0] delay_outer_left  = vg_pkg::wrdelay_outer_left,
	parameter logic [3:0] delay_outer_right = vg_pkg::wrdelay_outer_right,
	parameter logic [3:0] delay_inner_left  = vg_pkg::wrdelay_inner_left,
	parameter logic [3:0] delay_inner_right = vg_pkg::wrdelay_inner_right,
	parameter logic [3:0] delay_standard    = vg_pkg::wrdelay_standard
)
(
	input  logic                 fclk,
	input  logic                 rst_n,
	input  vg_pkg::fdd_precomp_t precomp, // sl/tr43/sr from the vg93
	input  logic                 vg_wd,   // raw write data pulse
	output logic                 vg_wrd   // delayed, fixed width write pulse
);

	import vg_pkg::*;

	fdd_precomp_t   precomp_s1;
	fdd_precomp_t   precomp_s2;   // stable copy of the lines
	logic [2:0]     wd_sync;
	logic           wd_rise;      // start of a vg_wd pulse
	precomp_shift_e shift;
	logic [3:0]     delay_sel;
	logic [3:0]     delay_cnt;
	logic           delay_end;
	logic [3:0]     width_cnt;    // 0..8, bit 3 marks idle
	logic           width_ena;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			precomp_s1 <= '0;
			precomp_s2 <= '0;
			wd_sync    <= 3'b000;
		end
		else
		begin
			precomp_s1 <= precomp;
			precomp_s2 <= precomp_s1;
			wd_sync    <= {wd_sync[1:0], vg_wd};
		end
	end

	assign wd_rise = wd_sync[1] & ~wd_sync[2];

	// class decode, only the four legal combinations shift
	always_comb
	begin
		case ({precomp_s2.sl, precomp_s2.tr43, precomp_s2.sr})
			3'b100:  shift = shift_outer_left;
			3'b001:  shift = shift_outer_right;
			3'b110:  shift = shift_inner_left;
			3'b011:  shift = shift_inner_right;
			default: shift = shift_none;
		endcase
	end

	always_comb
	begin
		case (shift)
			shift_outer_left:  delay_sel = delay_outer_left;
			shift_outer_right: delay_sel = delay_outer_right;
			shift_inner_left:  delay_sel = delay_inner_left;
			shift_inner_right: delay_sel = delay_inner_right;
			default:           delay_sel = delay_standard;
		endcase
	end

	// delay down-counter, parks at zero
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			delay_cnt <= 4'd0;
		else if (wd_rise)
			delay_cnt <= delay_sel;
		else if (!delay_end)
			delay_cnt <= delay_cnt - 4'd1;
	end

	assign delay_end = (delay_cnt == 4'd0);

	// width counter held at 0 during the delay, then runs up to 8
	assign width_ena = wd_rise | (delay_end & ~width_cnt[3]);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			width_cnt <= 4'd8; // idle
		else if (width_ena)
		begin
			if (wd_rise)
				width_cnt <= 4'd0;
			else
				width_cnt <= width_cnt + 4'd1;
		end
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			vg_wrd <= 1'b0;
		else
			vg_wrd <= |width_cnt[2:0]; // counts 1..7 give the 7 cycle pulse
	end

endmodule

/* sim.f */
+incdir+tb
design/vg_pkg.sv
design/vg_clock_gen.sv
design/vg_sysreg.sv
design/vg_write_precomp.sv
design/vg_read_restore.sv
design/vg_subsys.sv
tb/tb_vg_subsys.sv

/* tb/tb_vg_model.svh */
`ifndef TB_VG_MODEL_SVH
`define TB_VG_MODEL_SVH

// expected timing in fclk edges, counted from the edge that samples the input
localparam int resync_edges = 2;  // vg_irq/vg_drq to intrq/drq
localparam int wrd_latency  = 4;  // vg_wrd rises at t+D+4
localparam int wrd_width    = 7;
localparam int rawr_low_at  = 7;  // first low rawr edge after the first low rdat sample
localparam int rawr_len     = 4;
localparam int rclk_first   = 37; // first toggle after an accepted pulse
localparam int rclk_settle  = 8;  // up to t+7 a toggle may still come from the old rhythm

// port #FF field mapping, side leaves inverted
function automatic vg_sys_t sys_after_write(input logic [7:0] d);
	vg_sys_t s;
	s.side      = ~d[4];
	s.hrdy      = d[3];
	s.res_n     = d[2];
	s.drive_sel = d[1:0];
	return s;
endfunction

// divide by 7, then 4 strobes per period normally or 2 in turbo
function automatic int clk_period_cycles(input bit turbo);
	return 7 * (turbo ? 2 : 4);
endfunction

// sl or sr alone shift outer, with tr43 they shift inner, all else stays centred
function automatic precomp_shift_e shift_class(input fdd_precomp_t p);
	precomp_shift_e s;
	s = shift_none;
	if (p.sl && !p.sr)
		s = p.tr43 ? shift_inner_left : shift_outer_left;
	else if (p.sr && !p.sl)
		s = p.tr43 ? shift_inner_right : shift_outer_right;
	return s;
endfunction

function automatic int wrd_rise_offset(input fdd_precomp_t p);
	logic [3:0] d;
	case (shift_class(p))
		shift_outer_left:  d = wrdelay_outer_left;
		shift_outer_right: d = wrdelay_outer_right;
		shift_inner_left:  d = wrdelay_inner_left;
		shift_inner_right: d = wrdelay_inner_right;
		default:           d = wrdelay_standard;
	endcase
	return int'(d) + wrd_latency;
endfunction

// rawr level after edge n for a pulse whose first low sample was edge t
function automatic logic rawr_level(input int n, input int t);
	return (n >= t + rawr_low_at && n < t + rawr_low_at + rawr_len) ? 1'b0 : 1'b1;
endfunction

// true when vg_rclk should have toggled at edge n
function automatic logic rclk_toggles_at(input int n, input int t);
	int k;
	k = n - t - rclk_first;
	return (k >= 0) && (k % int'(rclk_half_default) == 0);
endfunction

`endif

/* tb/tb_vg_subsys.sv */
`timescale 1ns/1ps

module tb_vg_subsys;

	import vg_pkg::*;

	`include "tb_vg_model.svh"

	localparam int clk_period     = 100; // ns
	localparam int reset_cycles   = 8;
	localparam int port_ff_writes = 50;
	localparam int resync_changes = 60;
	localparam int precomp_count  = 40;
	localparam int read_pulses    = 60;
	localparam int glitch_pulses  = 40;
	// worst case per test: 300 + 360 + 650 + 1600 + 12500 + 1300 cycles, doubled and rounded up
	localparam int cycle_limit    = 40000;

	logic         fclk;
	logic         rst_n;
	logic [7:0]   din;
	logic         wr_ff;
	vg_sys_t      sys;
	logic         intrq;
	logic         drq;
	logic         vg_irq;
	logic         vg_drq;
	logic         step;
	logic         vg_clk;
	fdd_precomp_t precomp;
	logic         vg_wd;
	logic         vg_wrd;
	logic         rdat_n;
	logic         vg_rawr;
	logic         vg_rclk;

	int    cyc;        // rising edges so far
	int    checks;
	int    errors;
	int    tests;
	int    test_checks0;
	int    test_errors0;
	string cur_test;
	int    rd_t_cur;   // first low sample of the last accepted read pulse, -1 for none
	int    rd_t_prev;

	vg_subsys vg_subsys_inst
	(
		.fclk    (fclk),
		.rst_n   (rst_n),
		.din     (din),
		.wr_ff   (wr_ff),
		.sys     (sys),
		.intrq   (intrq),
		.drq     (drq),
		.vg_irq  (vg_irq),
		.vg_drq  (vg_drq),
		.step    (step),
		.vg_clk  (vg_clk),
		.precomp (precomp),
		.vg_wd   (vg_wd),
		.vg_wrd  (vg_wrd),
		.rdat_n  (rdat_n),
		.vg_rawr (vg_rawr),
		.vg_rclk (vg_rclk)
	);

	initial
	begin
		fclk = 1'b0;
		forever #(clk_period / 2) fclk = ~fclk;
	end

	// edge counter and run limit
	always @(posedge fclk)
	begin
		cyc = cyc + 1;
		if (cyc >= cycle_limit)
		begin
			$display("timeout: run still going after %0d cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	// outputs are read and inputs driven 1 ns after the edge
	task automatic next_cycle();
		@(posedge fclk);
		#1;
	endtask

	task automatic check_sys(input string what, input vg_sys_t exp, input vg_sys_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("ERR %s %s at cycle %0d: expected %b actual %b", cur_test, what, cyc, exp, act);
		end
	endtask

	task automatic check_period(input string what, input int exp, input int act);
		checks++;
		if (exp != act)
		begin
			errors++;
			$display("ERR %s %s: expected %0d actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("%s: %s", cur_test, what);
	endtask

	task automatic begin_test(input string name);
		cur_test     = name;
		test_checks0 = checks;
		test_errors0 = errors;
		tests++;
	endtask

	task automatic end_test();
		$display("test %-14s %0d checks, %0d errors", cur_test, checks - test_checks0,
			errors - test_errors0);
	endtask

	task automatic reset_and_port_ff();
		vg_sys_t exp_sys;
		int      idle;
		begin_test("reset_port_ff");
		exp_sys = '0; // res_n low, everything else clear
		check_sys("sys after reset", exp_sys, sys);
		check_bit("vg_wrd after reset", 1'b0, vg_wrd);
		check_bit("vg_rawr after reset", 1'b1, vg_rawr);
		check_bit("vg_rclk after reset", 1'b0, vg_rclk);
		check_bit("vg_clk after reset", 1'b0, vg_clk);
		for (int i = 0; i < port_ff_writes; i++)
		begin
			din   = 8'($urandom);
			wr_ff = 1'b1;
			next_cycle(); // strobe sampled here
			wr_ff = 1'b0;
			check_sys("sys at strobe edge", exp_sys, sys);
			next_cycle();
			exp_sys = sys_after_write(din);
			check_sys("sys after write", exp_sys, sys);
			din  = 8'($urandom); // bus noise while idle
			idle = $urandom_range(3, 0);
			repeat (idle) next_cycle();
		end
		end_test();
	endtask

	task automatic resync_levels();
		logic irq_seen [0:resync_edges]; // [k] is the level seen k edges ago
		logic drq_seen [0:resync_edges];
		int   hold;
		begin_test("resync");
		for (int k = 0; k <= resync_edges; k++)
		begin
			irq_seen[k] = vg_irq;
			drq_seen[k] = vg_drq;
		end
		for (int i = 0; i < resync_changes; i++)
		begin
			vg_irq = 1'($urandom);
			vg_drq = 1'($urandom);
			hold   = $urandom_range(6, 3);
			repeat (hold)
			begin
				next_cycle();
				for (int k = resync_edges; k > 0; k--)
				begin
					irq_seen[k] = irq_seen[k - 1];
					drq_seen[k] = drq_seen[k - 1];
				end
				irq_seen[0] = vg_irq;
				drq_seen[0] = vg_drq;
				check_bit("intrq", irq_seen[resync_edges], intrq);
				check_bit("drq", drq_seen[resync_edges], drq);
			end
		end
		vg_irq = 1'b0;
		vg_drq = 1'b0;
		repeat (4) next_cycle();
		end_test();
	endtask

	task automatic wait_clk_rise();
		logic prev;
		prev = vg_clk;
		next_cycle();
		while (!(vg_clk && !prev))
		begin
			prev = vg_clk;
			next_cycle();
		end
	endtask

	// one partial and two full periods pass before the measured one
	task automatic measure_clk_period(output int period);
		int start;
		repeat (3) wait_clk_rise();
		start = cyc;
		wait_clk_rise();
		period = cyc - start;
	endtask

	// 3 cycle pulse on step and/or vg_drq, then time for the turbo fsm to follow
	task automatic raise_lines(input logic do_step, input logic do_drq);
		step   = do_step;
		vg_drq = do_drq;
		repeat (3) next_cycle();
		step   = 1'b0;
		vg_drq = 1'b0;
		repeat (4) next_cycle();
	endtask

	task automatic clock_turbo_periods();
		int period;
		begin_test("clock_turbo");
		measure_clk_period(period);
		check_period("period after reset", clk_period_cycles(1'b0), period);
		raise_lines(1'b1, 1'b0);
		measure_clk_period(period);
		check_period("period after step", clk_period_cycles(1'b1), period);
		raise_lines(1'b0, 1'b1);
		measure_clk_period(period);
		check_period("period after drq", clk_period_cycles(1'b0), period);
		raise_lines(1'b1, 1'b0);
		measure_clk_period(period);
		check_period("period after second step", clk_period_cycles(1'b1), period);
		raise_lines(1'b1, 1'b1); // drq wins
		measure_clk_period(period);
		check_period("period after step with drq", clk_period_cycles(1'b0), period);
		end_test();
	endtask

	task automatic precomp_delay_pulses();
		fdd_precomp_t pc;
		int           k;
		int           n;
		int           gap;
		int           offset;
		int           width;
		begin_test("precomp");
		for (int i = 0; i < precomp_count; i++)
		begin
			pc      = 3'($urandom);
			precomp = pc;
			vg_wd   = 1'b1;
			k       = cyc; // t is k + 1
			gap     = $urandom_range(40, 24);
			n       = 0;
			offset  = -1;
			while (offset < 0 && n < 30)
			begin
				next_cycle();
				n++;
				if (n == 2)
					vg_wd = 1'b0; // two samples high
				if (vg_wrd)
					offset = cyc - (k + 1);
			end
			if (offset < 0)
				note_failure("vg_wrd never went high after a vg_wd pulse");
			else
			begin
				check_period("vg_wrd rise offset", wrd_rise_offset(pc), offset);
				width = 0;
				while (vg_wrd && width < 20)
				begin
					width++;
					next_cycle();
				end
				check_period("vg_wrd width", wrd_width, width);
			end
			while (cyc < k + gap)
				next_cycle();
		end
		end_test();
	endtask

	// read pulses or short glitches, rawr and rclk checked on every edge
	task automatic read_pulse_sequence(input string name, input logic glitch, input int pulses);
		int   low_left;
		int   next_k;
		int   sent;
		int   ref_t;
		logic rclk_prev;
		logic toggled;
		begin_test(name);
		low_left  = 0;
		sent      = 0;
		next_k    = cyc + 10;
		rclk_prev = vg_rclk;
		while (sent < pulses || low_left > 0 || cyc < next_k)
		begin
			next_cycle();
			check_bit("vg_rawr", rawr_level(cyc, rd_t_cur), vg_rawr);
			ref_t   = (cyc >= rd_t_cur + rclk_settle) ? rd_t_cur : rd_t_prev;
			toggled = (vg_rclk !== rclk_prev);
			if (ref_t >= 0)
				check_bit("vg_rclk toggle", rclk_toggles_at(cyc, ref_t), toggled);
			rclk_prev = vg_rclk;
			if (low_left > 0)
			begin
				low_left--;
				if (low_left == 0)
					rdat_n = 1'b1;
			end
			else if (cyc == next_k && sent < pulses)
			begin
				rdat_n = 1'b0;
				sent++;
				if (glitch)
				begin
					low_left = $urandom_range(3, 1); // too short for the filter
					next_k   = cyc + $urandom_range(30, 8);
				end
				else
				begin
					low_left  = $urandom_range(8, 4);
					next_k    = cyc + $urandom_range(200, 60);
					rd_t_prev = rd_t_cur;
					rd_t_cur  = cyc + 1;
				end
			end
		end
		end_test();
	endtask

	initial
	begin
		int seed;
		seed      = $urandom(32'hd6f4);
		cyc       = 0;
		checks    = 0;
		errors    = 0;
		tests     = 0;
		rd_t_cur  = -1;
		rd_t_prev = -1;
		rst_n     = 1'b0;
		din       = 8'h00;
		wr_ff     = 1'b0;
		vg_irq    = 1'b0;
		vg_drq    = 1'b0;
		step      = 1'b0;
		precomp   = '0;
		vg_wd     = 1'b0;
		rdat_n    = 1'b1; // idle high
		repeat (reset_cycles) next_cycle();
		rst_n = 1'b1;
		reset_and_port_ff();
		resync_levels();
		clock_turbo_periods();
		precomp_delay_pulses();
		read_pulse_sequence("read_restore", 1'b0, read_pulses);
		read_pulse_sequence("glitch_reject", 1'b1, glitch_pulses); // rhythm of the last pulse goes on
		$display("summary: %0d tests, %0d checks, %0d errors, %0d cycles", tests, checks, errors,
			cyc);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
